// ==== Bender.yml ====
package:
  name: adpcma

sources:
  - verilog/adpcma_pkg.sv
  - verilog/adpcma_slot_if.sv
  - verilog/adpcma_addr_gen.sv
  - verilog/adpcma_decoder.sv
  - verilog/adpcma_level_regs.sv
  - verilog/adpcma_mixer.sv
  - verilog/adpcma_drv.sv
  - target: simulation
    files:
      - verification/adpcma_tb.sv

// ==== files.f ====
verilog/adpcma_pkg.sv
verilog/adpcma_slot_if.sv
verilog/adpcma_addr_gen.sv
verilog/adpcma_decoder.sv
verilog/adpcma_level_regs.sv
verilog/adpcma_mixer.sv
verilog/adpcma_drv.sv
verification/adpcma_tb.sv

// ==== verification/adpcma_tb.sv ====
// Directed testbench for the ADPCM-A engine, with a ROM model and a reference decoder/mixer.
// Frame checks start one frame after a key command issued right after the slot 5 address.
`timescale 1ns/1ps

module adpcma_tb;
    import adpcma_pkg::*;

    localparam int CLK_NS       = 10;
    localparam int CEN_NS       = 4 * CLK_NS;
    localparam int FRAME_BUDGET = 4 + 530 + 45 + 75 + 65 + 90 + 40;  // per test, plus key cmds
    localparam int WATCHDOG_NS  = FRAME_BUDGET * 8 * CEN_NS + 50_000;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    cen;
    slot_t                   ch;
    logic [REG_ADDR_W-1:0]   addr_in;
    logic                    we_start, we_end, we_lracl, we_aon;
    logic [7:0]              lracl_in, aon_cmd, datain;
    logic [5:0]              atl;
    logic [ADDR_W-1:0]       addr;
    logic                    roe_n, frame_done;
    logic signed [OUT_W-1:0] pcm_l, pcm_r;

    logic [7:0]  rom [0:(1 << ADDR_W) - 1];
    logic [1:0]  cen_div;
    logic [2:0]  cur_slot;  // slot the next cen addresses
    logic [31:0] rng;
    int          err_total, test_errs, tests_run, tests_failed;

    // reference model state
    int         m_cnt [NUM_CH];
    int         m_sig [NUM_CH];
    int         m_idx [NUM_CH];
    bit         m_sel [NUM_CH];
    bit         m_active [NUM_CH];
    int         cfg_start [NUM_CH];
    int         cfg_end [NUM_CH];
    logic [7:0] cfg_lr [NUM_CH];
    int         cfg_atl;

    adpcma_drv u_dut (
        .clk(clk), .rst_n(rst_n), .cen(cen), .ch(ch), .addr_in(addr_in),
        .we_start(we_start), .we_end(we_end), .lracl_in(lracl_in), .we_lracl(we_lracl),
        .atl(atl), .aon_cmd(aon_cmd), .we_aon(we_aon), .datain(datain),
        .addr(addr), .roe_n(roe_n), .pcm_l(pcm_l), .pcm_r(pcm_r), .frame_done(frame_done)
    );

    assign datain = rom[addr];  // combinational ROM

    always #(CLK_NS / 2) clk = ~clk;

    always @(posedge clk) begin
        cen_div <= cen_div + 2'd1;
        cen     <= (cen_div == 2'd3);  // one cycle in four
        if (!rst_n) begin
            cur_slot <= '0;
        end else if (cen) begin
            cur_slot <= (cur_slot == 3'd5) ? 3'd0 : cur_slot + 3'd1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in its time budget");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int scale_sample(input int s, input int lvl);
        int a;
        a = (63 - cfg_atl) + (31 - lvl);
        return (s * int'(GAIN_MANT[a % 8])) >>> (a / 8 + 4);
    endfunction

    // one frame of the reference: every channel decodes one nibble
    task automatic ref_frame(output int el, output int er);
        int sl, sr, b, nib, mag, diff, v;
        sl = 0;
        sr = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (m_active[c]) begin
                b    = rom[m_cnt[c]];
                nib  = m_sel[c] ? (b & 15) : (b >> 4);
                mag  = nib & 7;
                diff = ((2 * mag + 1) * int'(STEP_TABLE[m_idx[c]])) / 8;
                m_sig[c] = (nib & 8) ? m_sig[c] - diff : m_sig[c] + diff;
                if (m_sig[c] > 2047) m_sig[c] = 2047;
                if (m_sig[c] < -2048) m_sig[c] = -2048;
                m_idx[c] = m_idx[c] + int'(INDEX_ADJ[mag]);
                if (m_idx[c] < 0) m_idx[c] = 0;
                if (m_idx[c] > 48) m_idx[c] = 48;
                if (m_sel[c]) begin
                    if (m_cnt[c] == ((cfg_end[c] << 8) | 255)) m_active[c] = 1'b0;
                    else m_cnt[c] = m_cnt[c] + 1;
                end
                m_sel[c] = !m_sel[c];
                v = scale_sample(m_sig[c], int'(cfg_lr[c][4:0]));
                if (cfg_lr[c][7]) sl = sl + v;
                if (cfg_lr[c][6]) sr = sr + v;
            end
        end
        el = (sl > 32767) ? 32767 : ((sl < -32768) ? -32768 : sl);
        er = (sr > 32767) ? 32767 : ((sr < -32768) ? -32768 : sr);
    endtask

    task automatic wait_frame();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!frame_done && cycles < 400);
        assert (frame_done) else begin
            $display("no frame_done pulse within 400 clock cycles");
            test_errs++;
        end
    endtask

    task automatic check_frame(input string name);
        int el, er;
        ref_frame(el, er);
        wait_frame();
        assert (pcm_l == el) else begin
            $display("FAILED %s: pcm_l expected %0d, actual %0d", name, el, pcm_l);
            test_errs++;
        end
        assert (pcm_r == er) else begin
            $display("FAILED %s: pcm_r expected %0d, actual %0d", name, er, pcm_r);
            test_errs++;
        end
    endtask

    task automatic set_start_reg(input int c, input int v);
        @(posedge clk);
        ch       <= slot_t'(c);
        addr_in  <= REG_ADDR_W'(v);
        we_start <= 1'b1;
        @(posedge clk);
        we_start <= 1'b0;
        cfg_start[c] = v;
    endtask

    task automatic set_end_reg(input int c, input int v);
        @(posedge clk);
        ch      <= slot_t'(c);
        addr_in <= REG_ADDR_W'(v);
        we_end  <= 1'b1;
        @(posedge clk);
        we_end <= 1'b0;
        cfg_end[c] = v;
    endtask

    task automatic set_level_pan(input int c, input logic [7:0] v);
        @(posedge clk);
        ch       <= slot_t'(c);
        lracl_in <= v;
        we_lracl <= 1'b1;
        @(posedge clk);
        we_lracl <= 1'b0;
        cfg_lr[c] = v;
    endtask

    task automatic set_total_level(input int v);
        @(posedge clk);
        atl <= 6'(v);
        cfg_atl = v;
    endtask

    // issued right after the slot 5 address, so the next frame starts clean
    task automatic key_command(input logic [7:0] cmd);
        do @(posedge clk); while (!(cen && cur_slot == 3'd5));
        aon_cmd <= cmd;
        we_aon  <= 1'b1;
        @(posedge clk);
        we_aon <= 1'b0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (cmd[c] && !cmd[7]) begin
                m_active[c] = 1'b1;
                m_cnt[c]    = cfg_start[c] << 8;
                m_sel[c]    = 1'b0;
                m_sig[c]    = 0;
                m_idx[c]    = 0;
            end else if (cmd[c]) begin
                m_active[c] = 1'b0;
            end
        end
        wait_frame();  // frame already in flight
    endtask

    task automatic wait_slot_addr(input int c);
        do @(posedge clk); while (!(cen && cur_slot == 3'(c)));
        @(negedge clk);
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_failed++;
        end
        err_total += test_errs;
        test_errs = 0;
    endtask

    task automatic test_idle();
        for (int f = 0; f < 4; f++) begin
            check_frame("idle");
            assert (roe_n) else begin
                $display("roe_n went low with no channel keyed on");
                test_errs++;
            end
        end
        close_test("idle");
    endtask

    task automatic test_addr_seq();
        int exp_a;
        set_start_reg(4, 12'h0A3);
        set_end_reg(4, 12'h0A3);
        key_command(8'h10);
        for (int i = 0; i < 512; i++) begin
            wait_slot_addr(4);
            exp_a = (12'h0A3 << 8) + i / 2;
            assert (addr == exp_a && !roe_n) else begin
                $display("FAILED addr_seq: addr expected %h, actual %h (roe_n %b)",
                         exp_a, addr, roe_n);
                test_errs++;
                break;
            end
        end
        for (int i = 0; i < 3; i++) begin
            wait_slot_addr(4);
            assert (roe_n) else begin
                $display("roe_n low in slot 4 after the channel reached its end");
                test_errs++;
            end
        end
        key_command(8'hBF);
        close_test("addr_seq");
    endtask

    task automatic test_decode();
        for (int i = 0; i < 256; i++) begin
            rom[(12'h010 << 8) + i] = 8'(i * 53 + 113);
        end
        set_start_reg(2, 12'h010);
        set_end_reg(2, 12'h010);
        set_level_pan(2, 8'hDF);
        set_total_level(63);
        key_command(8'h04);
        for (int f = 0; f < 40; f++) check_frame("decode");
        key_command(8'hBF);
        close_test("decode");
    endtask

    task automatic test_pan_level();
        logic [7:0] lr [3];
        int         tl [3];
        lr = '{8'h9B, 8'h54, 8'h1F};  // left only, right only, muted
        tl = '{60, 55, 63};
        set_start_reg(1, 12'h200);
        set_end_reg(1, 12'h201);
        for (int k = 0; k < 3; k++) begin
            set_level_pan(1, lr[k]);
            set_total_level(tl[k]);
            key_command(8'h02);
            for (int f = 0; f < 20; f++) check_frame("pan_level");
            key_command(8'h82);
        end
        close_test("pan_level");
    endtask

    task automatic test_six_mix();
        for (int c = 0; c < NUM_CH; c++) begin
            rng = lcg_next(rng);
            set_start_reg(c, 12'h400 + c * 4);
            set_end_reg(c, 12'h401 + c * 4);
            set_level_pan(c, {rng[31:30], 1'b0, rng[20:16]});
        end
        rng = lcg_next(rng);
        set_total_level(63 - int'(rng[25:24]));
        key_command(8'h3F);
        for (int f = 0; f < 60; f++) check_frame("six_mix");
        key_command(8'hBF);
        close_test("six_mix");
    endtask

    task automatic test_rekey();
        set_start_reg(3, 12'h300);
        set_end_reg(3, 12'h301);
        set_level_pan(3, 8'hDF);
        set_total_level(62);
        key_command(8'h08);
        for (int f = 0; f < 30; f++) check_frame("rekey");
        key_command(8'h88);  // off in the middle of the sample
        for (int f = 0; f < 10; f++) check_frame("rekey");
        key_command(8'h08);
        for (int f = 0; f < 30; f++) check_frame("rekey");
        key_command(8'hBF);
        close_test("rekey");
    endtask

    initial begin
        rst_n    = 1'b0;
        cen      = 1'b0;
        cen_div  = '0;
        ch       = '0;
        addr_in  = '0;
        we_start = 1'b0;
        we_end   = 1'b0;
        lracl_in = '0;
        we_lracl = 1'b0;
        atl      = '0;
        aon_cmd  = '0;
        we_aon   = 1'b0;
        cfg_atl  = 0;
        err_total = 0;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            m_active[c] = 1'b0;
            cfg_lr[c]   = '0;
            cfg_start[c] = 0;
            cfg_end[c]  = 0;
        end
        rng = 32'h7fd7_a863;
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            rng    = lcg_next(rng);
            rom[a] = rng[31:24] ^ a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]};
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_idle();
        test_addr_seq();
        test_decode();
        test_pan_level();
        test_six_mix();
        test_rekey();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/adpcma_addr_gen.sv ====
// Slot counter and six interleaved ROM address counters.
// Key commands take effect on any clk; writes with ch above 5 are ignored.
`timescale 1ns/1ps

module adpcma_addr_gen (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cen,
    input  adpcma_pkg::slot_t                   ch,
    input  logic [adpcma_pkg::REG_ADDR_W-1:0]   addr_in,
    input  logic                                we_start,
    input  logic                                we_end,
    input  logic [7:0]                          aon_cmd,
    input  logic                                we_aon,
    output logic [adpcma_pkg::ADDR_W-1:0]       addr,
    output logic                                roe_n,
    output adpcma_pkg::slot_t                   slot,
    output logic                                nibble_sel,
    output logic                                ch_active,
    output logic [adpcma_pkg::NUM_CH-1:0]       key_on_pulse
);
    import adpcma_pkg::*;

    logic [REG_ADDR_W-1:0] start_r [NUM_CH];
    logic [REG_ADDR_W-1:0] end_r   [NUM_CH];
    logic [ADDR_W-1:0]     cnt     [NUM_CH];
    logic [NUM_CH-1:0]     sel;         // 0 = upper nibble next
    logic [NUM_CH-1:0]     active;
    logic [NUM_CH-1:0]     key_mask;
    logic [NUM_CH-1:0]     key_off;
    slot_t                 slot_cnt;

    assign key_mask     = aon_cmd[NUM_CH-1:0] & {NUM_CH{we_aon}};
    assign key_on_pulse = key_mask & {NUM_CH{~aon_cmd[7]}};
    assign key_off      = key_mask & {NUM_CH{aon_cmd[7]}};

    always_ff @(posedge clk) begin
        if (we_start && ch <= LAST_SLOT) begin
            start_r[ch] <= addr_in;
        end
        if (we_end && ch <= LAST_SLOT) begin
            end_r[ch] <= addr_in;
        end
    end

    // only the channel of the current slot moves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel    <= '0;
            active <= '0;
            for (int i = 0; i < NUM_CH; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (key_on_pulse[i]) begin
                    cnt[i]    <= {start_r[i], {PAGE_W{1'b0}}};
                    sel[i]    <= 1'b0;
                    active[i] <= 1'b1;
                end else if (key_off[i]) begin
                    active[i] <= 1'b0;
                end else if (cen && active[i] && slot_cnt == slot_t'(i)) begin
                    sel[i] <= ~sel[i];
                    if (sel[i]) begin  // lower nibble done, move on
                        if (cnt[i] == {end_r[i], {PAGE_W{1'b1}}}) begin
                            active[i] <= 1'b0;
                        end else begin
                            cnt[i] <= cnt[i] + 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_cnt   <= '0;
            addr       <= '0;
            roe_n      <= 1'b1;
            slot       <= '0;
            nibble_sel <= 1'b0;
            ch_active  <= 1'b0;
        end else if (cen) begin
            slot_cnt   <= (slot_cnt == LAST_SLOT) ? '0 : slot_cnt + 1'b1;
            addr       <= cnt[slot_cnt];
            slot       <= slot_cnt;
            nibble_sel <= sel[slot_cnt];
            ch_active  <= active[slot_cnt] && !key_mask[slot_cnt];
            roe_n      <= !(active[slot_cnt] && !key_mask[slot_cnt]);
        end else if (key_mask[slot]) begin  // drop the byte in flight
            ch_active <= 1'b0;
            roe_n     <= 1'b1;
        end
    end

endmodule

// ==== verilog/adpcma_decoder.sv ====
// Time-multiplexed ADPCM-A nibble decoder, one channel state per slot.
// datain must be stable at the cen after the address was issued.
`timescale 1ns/1ps

module adpcma_decoder (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cen,
    input  logic [7:0]                     datain,
    input  adpcma_pkg::slot_t              slot,
    input  logic                           nibble_sel,
    input  logic                           ch_active,
    input  logic [adpcma_pkg::NUM_CH-1:0]  key_on_pulse,
    adpcma_slot_if.dec                     smp
);
    import adpcma_pkg::*;

    logic signed [SMP_W-1:0]   sig_r [NUM_CH];
    logic [STEP_IDX_W-1:0]     idx_r [NUM_CH];
    logic [3:0]                nib;
    logic [STEP_W-1:0]         step;
    logic [STEP_W+3:0]         diff_full;
    logic [SMP_W-1:0]          diff;
    logic signed [SMP_W+1:0]   sig_ext;
    logic signed [SMP_W+1:0]   diff_ext;
    logic signed [SMP_W+1:0]   sum;
    logic signed [SMP_W-1:0]   sig_next;
    logic signed [STEP_IDX_W+1:0] idx_sum;
    logic [STEP_IDX_W-1:0]     idx_next;

    always_comb begin
        nib       = nibble_sel ? datain[3:0] : datain[7:4];  // upper nibble first
        step      = STEP_TABLE[idx_r[slot]];
        diff_full = {nib[2:0], 1'b1} * step;  // (2*mag+1)*step
        diff      = diff_full[STEP_W+3:3];
        sig_ext   = sig_r[slot];
        diff_ext  = {2'b00, diff};
        sum       = nib[3] ? sig_ext - diff_ext : sig_ext + diff_ext;
        if (sum > SMP_MAX) begin
            sig_next = SMP_W'(SMP_MAX);
        end else if (sum < SMP_MIN) begin
            sig_next = SMP_W'(SMP_MIN);
        end else begin
            sig_next = sum[SMP_W-1:0];
        end
        idx_sum = $signed({2'b00, idx_r[slot]}) + INDEX_ADJ[nib[2:0]];
        if (idx_sum < 0) begin
            idx_next = '0;
        end else if (idx_sum > STEP_LAST) begin
            idx_next = STEP_IDX_W'(STEP_LAST);
        end else begin
            idx_next = idx_sum[STEP_IDX_W-1:0];
        end
    end

    // key-on wins over a decode of the same channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                sig_r[i] <= '0;
                idx_r[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (key_on_pulse[i]) begin
                    sig_r[i] <= '0;
                    idx_r[i] <= '0;
                end else if (cen && ch_active && slot == slot_t'(i)) begin
                    sig_r[i] <= sig_next;
                    idx_r[i] <= idx_next;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            smp.valid  <= 1'b0;
            smp.slot   <= '0;
            smp.sample <= '0;
            smp.active <= 1'b0;
        end else begin
            smp.valid <= cen;
            if (cen) begin
                smp.slot   <= slot;
                smp.active <= ch_active;
                smp.sample <= ch_active ? sig_next : '0;  // silent when off
            end
        end
    end

endmodule

// ==== verilog/adpcma_drv.sv ====
// Six-channel ADPCM-A playback engine, one channel slot per cen.
// The ROM must answer addr on datain within one cen period.
`timescale 1ns/1ps

module adpcma_drv (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cen,
    input  adpcma_pkg::slot_t                   ch,
    input  logic [adpcma_pkg::REG_ADDR_W-1:0]   addr_in,
    input  logic                                we_start,
    input  logic                                we_end,
    input  logic [7:0]                          lracl_in,
    input  logic                                we_lracl,
    input  logic [5:0]                          atl,
    input  logic [7:0]                          aon_cmd,
    input  logic                                we_aon,
    input  logic [7:0]                          datain,
    output logic [adpcma_pkg::ADDR_W-1:0]       addr,
    output logic                                roe_n,
    output logic signed [adpcma_pkg::OUT_W-1:0] pcm_l,
    output logic signed [adpcma_pkg::OUT_W-1:0] pcm_r,
    output logic                                frame_done
);
    import adpcma_pkg::*;

    slot_t               slot;
    slot_t               mix_slot;
    logic                nibble_sel;
    logic                ch_active;
    logic [NUM_CH-1:0]   key_on_pulse;
    logic [ATTEN_W-1:0]  atten;
    logic                left_en;
    logic                right_en;

    adpcma_slot_if u_smp ();

    adpcma_addr_gen u_addr_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .cen          (cen),
        .ch           (ch),
        .addr_in      (addr_in),
        .we_start     (we_start),
        .we_end       (we_end),
        .aon_cmd      (aon_cmd),
        .we_aon       (we_aon),
        .addr         (addr),
        .roe_n        (roe_n),
        .slot         (slot),
        .nibble_sel   (nibble_sel),
        .ch_active    (ch_active),
        .key_on_pulse (key_on_pulse)
    );

    adpcma_decoder u_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .cen          (cen),
        .datain       (datain),
        .slot         (slot),
        .nibble_sel   (nibble_sel),
        .ch_active    (ch_active),
        .key_on_pulse (key_on_pulse),
        .smp          (u_smp)
    );

    adpcma_level_regs u_level_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .ch       (ch),
        .lracl_in (lracl_in),
        .we_lracl (we_lracl),
        .atl      (atl),
        .mix_slot (mix_slot),
        .atten    (atten),
        .left_en  (left_en),
        .right_en (right_en)
    );

    adpcma_mixer u_mixer (
        .clk        (clk),
        .rst_n      (rst_n),
        .cen        (cen),
        .atten      (atten),
        .left_en    (left_en),
        .right_en   (right_en),
        .smp        (u_smp),
        .mix_slot   (mix_slot),
        .pcm_l      (pcm_l),
        .pcm_r      (pcm_r),
        .frame_done (frame_done)
    );

endmodule

// ==== verilog/adpcma_level_regs.sv ====
// Per-channel level and pan registers plus the live total level.
// Lookup is combinational on the slot the mixer is about to add.
`timescale 1ns/1ps

module adpcma_level_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  adpcma_pkg::slot_t                 ch,
    input  logic [7:0]                        lracl_in,
    input  logic                              we_lracl,
    input  logic [5:0]                        atl,
    input  adpcma_pkg::slot_t                 mix_slot,
    output logic [adpcma_pkg::ATTEN_W-1:0]    atten,
    output logic                              left_en,
    output logic                              right_en
);
    import adpcma_pkg::*;

    logic [1:0] pan_r   [NUM_CH];  // {left, right}
    logic [4:0] level_r [NUM_CH];
    logic [4:0] level;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                pan_r[i]   <= '0;
                level_r[i] <= '0;
            end
        end else if (we_lracl && ch <= LAST_SLOT) begin
            pan_r[ch]   <= lracl_in[7:6];
            level_r[ch] <= lracl_in[4:0];
        end
    end

    always_comb begin
        level    = level_r[mix_slot];
        // (63 - atl) + (31 - level)
        atten    = {1'b0, ~atl} + {2'b00, ~level};
        left_en  = pan_r[mix_slot][1];
        right_en = pan_r[mix_slot][0];
    end

endmodule

// ==== verilog/adpcma_mixer.sv ====
// Gain, pan and stereo accumulation of the six channel samples.
// Sums saturate once per frame, when the slot 5 contribution lands.
`timescale 1ns/1ps

module adpcma_mixer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cen,
    input  logic [adpcma_pkg::ATTEN_W-1:0]      atten,
    input  logic                                left_en,
    input  logic                                right_en,
    adpcma_slot_if.mix                          smp,
    output adpcma_pkg::slot_t                   mix_slot,
    output logic signed [adpcma_pkg::OUT_W-1:0] pcm_l,
    output logic signed [adpcma_pkg::OUT_W-1:0] pcm_r,
    output logic                                frame_done
);
    import adpcma_pkg::*;

    logic                    have_smp;  // sample waiting for its cen
    logic                    take;
    logic [7:0]              mant;
    logic [3:0]              shift;
    logic signed [SMP_W+8:0] prod;
    logic signed [SMP_W+8:0] scaled;
    logic signed [ACC_W-1:0] contrib_l, contrib_r;
    logic signed [ACC_W-1:0] sum_l, sum_r;
    logic signed [ACC_W-1:0] acc_l, acc_r;

    function automatic logic signed [OUT_W-1:0] sat(input logic signed [ACC_W-1:0] v);
        if (v > OUT_MAX) begin
            return OUT_W'(OUT_MAX);
        end else if (v < OUT_MIN) begin
            return OUT_W'(OUT_MIN);
        end
        return v[OUT_W-1:0];
    endfunction

    assign mix_slot = smp.slot;  // level bank looks up this slot
    assign take     = cen && (have_smp || smp.valid);

    always_comb begin
        mant      = GAIN_MANT[atten[2:0]];
        shift     = atten[ATTEN_W-1:3] + 4'(GAIN_SHIFT);
        prod      = smp.sample * $signed({1'b0, mant});
        scaled    = prod >>> shift;
        contrib_l = (smp.active && left_en) ? ACC_W'(scaled) : '0;
        contrib_r = (smp.active && right_en) ? ACC_W'(scaled) : '0;
        sum_l     = acc_l + contrib_l;
        sum_r     = acc_r + contrib_r;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_smp   <= 1'b0;
            acc_l      <= '0;
            acc_r      <= '0;
            pcm_l      <= '0;
            pcm_r      <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (take) begin
                have_smp <= 1'b0;
                if (smp.slot == LAST_SLOT) begin  // close the frame
                    pcm_l      <= sat(sum_l);
                    pcm_r      <= sat(sum_r);
                    acc_l      <= '0;
                    acc_r      <= '0;
                    frame_done <= 1'b1;
                end else begin
                    acc_l <= sum_l;
                    acc_r <= sum_r;
                end
            end else if (smp.valid) begin
                have_smp <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/adpcma_pkg.sv ====
// Shared widths, tables and the slot tag of the six-channel ADPCM-A engine.
// Step and gain tables follow the YM2610 ADPCM-A arithmetic.
package adpcma_pkg;

    localparam int NUM_CH     = 6;
    localparam int ADDR_W     = 20;  // ROM byte address
    localparam int REG_ADDR_W = 12;  // start/end registers hold the upper bits
    localparam int PAGE_W     = ADDR_W - REG_ADDR_W;
    localparam int SMP_W      = 12;
    localparam int OUT_W      = 16;
    localparam int ACC_W      = OUT_W + 3;  // room for six full-scale channels
    localparam int ATTEN_W    = 7;
    localparam int STEP_W     = 11;
    localparam int STEP_IDX_W = 6;
    localparam int STEP_LAST  = 48;
    localparam int GAIN_SHIFT = 4;  // fixed shift on top of the 6 dB steps

    localparam int SMP_MAX = 2 ** (SMP_W - 1) - 1;
    localparam int SMP_MIN = -(2 ** (SMP_W - 1));
    localparam int OUT_MAX = 2 ** (OUT_W - 1) - 1;
    localparam int OUT_MIN = -(2 ** (OUT_W - 1));

    typedef logic [2:0] slot_t;

    localparam slot_t LAST_SLOT = slot_t'(NUM_CH - 1);

    localparam logic [STEP_W-1:0] STEP_TABLE [0:STEP_LAST] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    // index step per nibble magnitude
    localparam logic signed [4:0] INDEX_ADJ [0:7] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd5, 5'sd7, 5'sd9
    };

    // 0.75 dB per entry, eight entries span one 6 dB shift
    localparam logic [7:0] GAIN_MANT [0:7] = '{
        8'd255, 8'd234, 8'd215, 8'd197, 8'd181, 8'd166, 8'd152, 8'd139
    };

endpackage

// ==== verilog/adpcma_slot_if.sv ====
// One decoded sample per slot, from the decoder to the mixer.
// valid is a single clk pulse following the decoding cen.
`timescale 1ns/1ps

interface adpcma_slot_if;
    import adpcma_pkg::*;

    logic                    valid;   // fresh sample strobe
    slot_t                   slot;    // channel tag
    logic signed [SMP_W-1:0] sample;
    logic                    active;  // channel was keyed on

    modport dec (
        output valid,
        output slot,
        output sample,
        output active
    );

    modport mix (
        input valid,
        input slot,
        input sample,
        input active
    );

endinterface
